/* pong_screen.f */
+incdir+tb
src/pong_pkg.sv
src/paddle_tracker.sv
src/puck_mover.sv
src/frame_sequencer.sv
src/pong_screen.sv
tb/pong_screen_tb.sv

/* src/frame_sequencer.sv */
`default_nettype none

module frame_sequencer
        import pong_pkg::*;
#(
        parameter cycle_count_t idle_cycles = default_idle_cycles
) (
        input  logic        CLOCK_50,
        input  logic        KEY,
        input  coord_x_t    paddle_x,
        input  paddle_len_t paddle_length,
        input  coord_x_t    puck_x,
        input  coord_y_t    puck_y,
        input  logic        puck_missed,
        output logic        restart,
        output logic        paddle_step,
        output logic        puck_step,
        output coord_x_t    x,
        output coord_y_t    y,
        output colour_t     colour,
        output logic        plot
);

        draw_state_t  state;

        // raster counters, in the paddle states x_cnt is an offset from paddle_x
        coord_x_t     x_cnt;
        coord_y_t     y_cnt;
        cycle_count_t wait_cnt;

        // last offset to erase, one past the paddle unless that pixel is the border
        paddle_len_t  erase_last;

        assign erase_last = (paddle_x + paddle_length + 8'd1 == right_line) ?
                            paddle_length : paddle_length + 8'd1;

        // ============================================================
        // state and counter updates
        // ============================================================

        always_ff @(posedge CLOCK_50, negedge KEY) begin
                if (!KEY) begin
                        // reset goes straight into the clear so no restart pulse is seen
                        state    <= CLEAR;
                        x_cnt    <= '0;
                        y_cnt    <= '0;
                        wait_cnt <= '0;
                end else begin
                        case (state)
                        INIT: begin
                                x_cnt <= '0;
                                y_cnt <= '0;
                                state <= CLEAR;
                        end
                        CLEAR: begin
                                // one pixel per cycle in raster order
                                if (x_cnt == screen_width - 8'd1) begin
                                        x_cnt <= '0;
                                        if (y_cnt == screen_height - 7'd1) begin
                                                x_cnt <= left_line;
                                                y_cnt <= top_line;
                                                state <= TOP_LINE_DRAW;
                                        end else begin
                                                y_cnt <= y_cnt + 7'd1;
                                        end
                                end else begin
                                        x_cnt <= x_cnt + 8'd1;
                                end
                        end
                        TOP_LINE_DRAW: begin
                                // the top line ends on the corner where the right line starts
                                if (x_cnt == right_line)
                                        state <= RIGHT_LINE_DRAW;
                                else
                                        x_cnt <= x_cnt + 8'd1;
                        end
                        RIGHT_LINE_DRAW: begin
                                if (y_cnt == screen_height - 7'd1) begin
                                        x_cnt <= left_line;
                                        y_cnt <= top_line;
                                        state <= LEFT_LINE_DRAW;
                                end else begin
                                        y_cnt <= y_cnt + 7'd1;
                                end
                        end
                        LEFT_LINE_DRAW: begin
                                if (y_cnt == screen_height - 7'd1) begin
                                        wait_cnt <= '0;
                                        state    <= FRAME_WAIT;
                                end else begin
                                        y_cnt <= y_cnt + 7'd1;
                                end
                        end
                        FRAME_WAIT: begin
                                // idle_cycles + 1 cycles without plotting
                                if (wait_cnt == idle_cycles) begin
                                        x_cnt <= '0;
                                        state <= ERASE_PADDLE;
                                end else begin
                                        wait_cnt <= wait_cnt + 32'd1;
                                end
                        end
                        ERASE_PADDLE: begin
                                // the length may shrink mid-sweep, so the end test is >=
                                if (x_cnt >= erase_last) begin
                                        x_cnt <= '0;
                                        state <= STEP_PADDLE;
                                end else begin
                                        x_cnt <= x_cnt + 8'd1;
                                end
                        end
                        STEP_PADDLE: begin
                                // paddle_x takes its new value on this edge
                                state <= DRAW_PADDLE;
                        end
                        DRAW_PADDLE: begin
                                if (x_cnt >= paddle_length)
                                        state <= ERASE_PUCK;
                                else
                                        x_cnt <= x_cnt + 8'd1;
                        end
                        ERASE_PUCK: begin
                                state <= DRAW_PUCK;
                        end
                        DRAW_PUCK: begin
                                // a miss restarts the game with a fresh clear
                                if (puck_missed) begin
                                        state <= INIT;
                                end else begin
                                        wait_cnt <= '0;
                                        state    <= FRAME_WAIT;
                                end
                        end
                        default: begin
                                state <= INIT;
                        end
                        endcase
                end
        end

        // ============================================================
        // pixel stream and control pulses
        // ============================================================

        always_comb begin
                restart     = (state == INIT);
                paddle_step = (state == STEP_PADDLE);
                puck_step   = (state == ERASE_PUCK);
                x           = x_cnt;
                y           = y_cnt;
                colour      = colour_bg;
                plot        = 1'b0;
                case (state)
                CLEAR: begin
                        plot = 1'b1;
                end
                TOP_LINE_DRAW, RIGHT_LINE_DRAW, LEFT_LINE_DRAW: begin
                        colour = colour_border;
                        plot   = 1'b1;
                end
                ERASE_PADDLE: begin
                        x    = paddle_x + x_cnt;
                        y    = paddle_row;
                        plot = 1'b1;
                end
                DRAW_PADDLE: begin
                        x      = paddle_x + x_cnt;
                        y      = paddle_row;
                        colour = colour_paddle;
                        plot   = 1'b1;
                end
                ERASE_PUCK: begin
                        // the old position is still on the ports during the step
                        x    = puck_x;
                        y    = puck_y;
                        plot = 1'b1;
                end
                DRAW_PUCK: begin
                        x      = puck_x;
                        y      = puck_y;
                        colour = colour_puck;
                        plot   = ~puck_missed;
                end
                default: begin
                        plot = 1'b0;
                end
                endcase
        end

endmodule

`default_nettype wire

/* src/paddle_tracker.sv */
`default_nettype none

module paddle_tracker
        import pong_pkg::*;
#(
        parameter cycle_count_t shrink_cycles = default_shrink_cycles
) (
        input  logic        CLOCK_50,
        input  logic        KEY,
        input  logic        restart,
        input  logic        paddle_step,
        input  logic        move_right,
        input  logic        move_left,
        output coord_x_t    paddle_x,
        output paddle_len_t paddle_length
);

        // farthest left and right positions that keep the paddle off the borders
        coord_x_t     left_min;
        coord_x_t     right_max;
        coord_x_t     next_x;
        cycle_count_t shrink_cnt;

        assign left_min  = left_line + 8'd1;
        assign right_max = right_line - 8'd1 - paddle_length;

        // candidate position for the next step, already clamped
        always_comb begin
                next_x = paddle_x;
                if (move_right) begin
                        // right wins when both keys are held
                        if (paddle_x + paddle_move >= right_max)
                                next_x = right_max;
                        else
                                next_x = paddle_x + paddle_move;
                end else if (move_left) begin
                        if (paddle_x < left_min + paddle_move)
                                next_x = left_min;
                        else
                                next_x = paddle_x - paddle_move;
                end
        end

        // the paddle only moves once per frame, on the step pulse
        always_ff @(posedge CLOCK_50, negedge KEY) begin
                if (!KEY) begin
                        paddle_x <= paddle_x_start;
                end else if (restart) begin
                        paddle_x <= paddle_x_start;
                end else if (paddle_step) begin
                        paddle_x <= next_x;
                end
        end

        // ============================================================
        // shrink timer
        // ============================================================

        // the counter runs every cycle, independent of the frame pacing
        always_ff @(posedge CLOCK_50, negedge KEY) begin
                if (!KEY) begin
                        paddle_length <= paddle_len_start;
                        shrink_cnt    <= '0;
                end else if (restart) begin
                        paddle_length <= paddle_len_start;
                        shrink_cnt    <= '0;
                end else if (shrink_cnt == shrink_cycles) begin
                        shrink_cnt <= '0;
                        // stop shrinking once the minimum is reached
                        if (paddle_length > paddle_len_min)
                                paddle_length <= paddle_length - 8'd1;
                end else begin
                        shrink_cnt <= shrink_cnt + 32'd1;
                end
        end

endmodule

`default_nettype wire

/* src/pong_pkg.sv */
`default_nettype none

package pong_pkg;

        // ============================================================
        // vector types for quantities with a fixed meaning
        // ============================================================

        // a screen column, 0 to 159
        typedef logic [7:0] coord_x_t;

        // a screen row, 0 to 119
        typedef logic [6:0] coord_y_t;

        // the 3-bit colour code taken by the VGA adapter
        typedef logic [2:0] colour_t;

        // the paddle spans paddle_x up to paddle_x + length, both included
        typedef logic [7:0] paddle_len_t;

        // wide enough for a frame delay or shrink period of several seconds
        typedef logic [31:0] cycle_count_t;

        // states of the pixel drawing machine, in the order a frame visits them
        typedef enum logic [3:0] {
                INIT,
                CLEAR,
                TOP_LINE_DRAW,
                RIGHT_LINE_DRAW,
                LEFT_LINE_DRAW,
                FRAME_WAIT,
                ERASE_PADDLE,
                STEP_PADDLE,
                DRAW_PADDLE,
                ERASE_PUCK,
                DRAW_PUCK
        } draw_state_t;

        // ============================================================
        // screen geometry
        // ============================================================

        localparam coord_x_t screen_width  = 8'd160;
        localparam coord_y_t screen_height = 7'd120;

        // the borders sit on these columns and on this row
        localparam coord_x_t left_line  = 8'd5;
        localparam coord_x_t right_line = 8'd154;
        localparam coord_y_t top_line   = 7'd5;

        // the paddle lives on a single row near the bottom
        localparam coord_y_t    paddle_row       = 7'd115;
        localparam coord_x_t    paddle_x_start   = 8'd70;
        localparam paddle_len_t paddle_len_start = 8'd10;
        localparam paddle_len_t paddle_len_min   = 8'd3;
        localparam coord_x_t    paddle_move      = 8'd2;

        // where the puck starts after every restart
        localparam coord_x_t faceoff_x = 8'd80;
        localparam coord_y_t faceoff_y = 7'd60;

        // colour codes: black, yellow, white and purple
        localparam colour_t colour_bg     = 3'd0;
        localparam colour_t colour_border = 3'd6;
        localparam colour_t colour_paddle = 3'd7;
        localparam colour_t colour_puck   = 3'd5;

        // an eighth of a second per frame and twenty seconds per shrink at 50 MHz
        localparam cycle_count_t default_idle_cycles   = 32'd6250000;
        localparam cycle_count_t default_shrink_cycles = 32'd1000000000;

endpackage

`default_nettype wire

/* src/pong_screen.sv */
`default_nettype none

module pong_screen
        import pong_pkg::*;
#(
        parameter cycle_count_t idle_cycles   = default_idle_cycles,
        parameter cycle_count_t shrink_cycles = default_shrink_cycles
) (
        input  logic       CLOCK_50,
        input  logic [3:0] KEY,
        output coord_x_t   x,
        output coord_y_t   y,
        output colour_t    colour,
        output logic       plot
);

        logic        restart;
        logic        paddle_step;
        logic        puck_step;
        logic        move_right;
        logic        move_left;
        logic        puck_missed;
        coord_x_t    paddle_x;
        paddle_len_t paddle_length;
        coord_x_t    puck_x;
        coord_y_t    puck_y;

        // the push buttons read low while pressed, KEY[3] is the game reset
        assign move_right = ~KEY[0];
        assign move_left  = ~KEY[1];

        paddle_tracker #(
                .shrink_cycles(shrink_cycles)
        ) u_paddle (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .restart(restart),
                .paddle_step(paddle_step), .move_right(move_right), .move_left(move_left),
                .paddle_x(paddle_x), .paddle_length(paddle_length)
        );

        puck_mover u_puck (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .restart(restart), .puck_step(puck_step),
                .paddle_x(paddle_x), .paddle_length(paddle_length),
                .puck_x(puck_x), .puck_y(puck_y), .puck_missed(puck_missed)
        );

        frame_sequencer #(
                .idle_cycles(idle_cycles)
        ) u_seq (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .paddle_x(paddle_x),
                .paddle_length(paddle_length), .puck_x(puck_x), .puck_y(puck_y),
                .puck_missed(puck_missed), .restart(restart), .paddle_step(paddle_step),
                .puck_step(puck_step), .x(x), .y(y), .colour(colour), .plot(plot)
        );

endmodule

`default_nettype wire

/* src/puck_mover.sv */
`default_nettype none

module puck_mover
        import pong_pkg::*;
(
        input  logic        CLOCK_50,
        input  logic        KEY,
        input  logic        restart,
        input  logic        puck_step,
        input  coord_x_t    paddle_x,
        input  paddle_len_t paddle_length,
        output coord_x_t    puck_x,
        output coord_y_t    puck_y,
        output logic        puck_missed
);

        // one direction bit per axis, the puck always moves diagonally
        logic     dir_right;
        logic     dir_down;
        coord_x_t next_x;
        coord_y_t next_y;
        logic     on_paddle;

        assign next_x = dir_right ? puck_x + 8'd1 : puck_x - 8'd1;
        assign next_y = dir_down ? puck_y + 7'd1 : puck_y - 7'd1;

        // paddle span test on the position the puck is about to take
        assign on_paddle = (next_x >= paddle_x) && (next_x <= paddle_x + paddle_length);

        // ============================================================
        // position, direction and miss flag
        // ============================================================

        always_ff @(posedge CLOCK_50, negedge KEY) begin
                if (!KEY) begin
                        puck_x      <= faceoff_x;
                        puck_y      <= faceoff_y;
                        dir_right   <= 1'b1;
                        dir_down    <= 1'b1;
                        puck_missed <= 1'b0;
                end else if (restart) begin
                        puck_x      <= faceoff_x;
                        puck_y      <= faceoff_y;
                        dir_right   <= 1'b1;
                        dir_down    <= 1'b1;
                        puck_missed <= 1'b0;
                end else if (puck_step) begin
                        puck_x      <= next_x;
                        puck_y      <= next_y;
                        puck_missed <= 1'b0;

                        // bounce off the row just under the top border
                        if (next_y == top_line + 7'd1)
                                dir_down <= ~dir_down;

                        // bounce off the columns just inside the side borders
                        if ((next_x == left_line + 8'd1) || (next_x == right_line - 8'd1))
                                dir_right <= ~dir_right;

                        // the row above the paddle decides between a bounce and a miss
                        if (next_y == paddle_row - 7'd1) begin
                                if (on_paddle)
                                        dir_down <= ~dir_down;
                                else
                                        puck_missed <= 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

/* tb/screen_checks.svh */
// ============================================================
// pixel level checks
// ============================================================

task automatic expect_eq(input string name, input int got, input int exp);
        assert (got == exp)
        else fail_run($sformatf("MISMATCH %s expected 0x%0h got 0x%0h", name, exp, got));
endtask

// a negative gap means the quiet cycles in front of the pixel are not checked
task automatic pixel_is(input int ex, input int ey, input int ec, input int eg);
        if (eg >= 0)
                expect_eq("plot low cycles", gap, eg);
        expect_eq("x", px, ex);
        expect_eq("y", py, ey);
        expect_eq("colour", pc, ec);
endtask

// the whole screen in raster order starting from the pixel already read
task automatic clear_pass;
        int i;
        pixel_is(0, 0, colour_bg, -1);
        for (i = 1; i < int'(screen_width) * int'(screen_height); i++) begin
                read_pixel;
                pixel_is(i % int'(screen_width), i / int'(screen_width), colour_bg, 0);
        end
endtask

// the top line left to right and then the right and left columns downwards
task automatic border_pass;
        int i;
        for (i = left_line; i <= right_line; i++) begin
                read_pixel;
                pixel_is(i, top_line, colour_border, 0);
        end
        for (i = top_line; i < screen_height; i++) begin
                read_pixel;
                pixel_is(right_line, i, colour_border, 0);
        end
        for (i = top_line; i < screen_height; i++) begin
                read_pixel;
                pixel_is(left_line, i, colour_border, 0);
        end
endtask

// ============================================================
// paddle rules
// ============================================================

task automatic paddle_pixel(input int left, input int k, input int ec, input int eg);
        pixel_is(left + k, paddle_row, ec, eg);
        assert (px > left_line && px < right_line)
        else fail_run($sformatf("paddle pixel at column 0x%0h touches a border", px));
endtask

task automatic erase_covers(input int count);
        assert (count >= prev_width)
        else fail_run("the paddle erase is shorter than the old paddle");
endtask

task automatic paddle_span_rules;
        int delta;
        delta = last_left - prev_left;
        assert (last_width >= int'(paddle_len_min) + 1)
        else fail_run($sformatf("paddle width 0x%0h is below the minimum", last_width));
        assert (last_width <= prev_width)
        else fail_run("the paddle grew during a game");
        // the move follows the key held at the step and right wins over left
        if (go_right) begin
                assert (delta >= 0 && delta <= int'(paddle_move))
                else fail_run("the paddle did not move right as the key asked");
        end else if (go_left) begin
                assert (delta <= 0 && delta >= -int'(paddle_move))
                else fail_run("the paddle did not move left as the key asked");
        end else begin
                expect_eq("paddle column", last_left, prev_left);
        end
endtask

// ============================================================
// puck rules
// ============================================================

task automatic puck_draw_rules;
        assert ((px - purple_x == 1 || purple_x - px == 1) &&
                (py - purple_y == 1 || purple_y - py == 1))
        else fail_run("the puck did not move one pixel on each axis");
        assert (px > left_line && px < right_line && py > top_line && py < paddle_row)
        else fail_run("the puck left the playing field");
        pixel_is(mx, my, colour_puck, 0);
endtask

// a miss blanks the puck and goes back to a fresh clear after the restart cycle
task automatic restart_rules;
        pixel_is(0, 0, colour_bg, 2);
endtask

/* tb/pong_screen_tb.sv */
`default_nettype none

module pong_screen_tb
        import pong_pkg::*;
();

        // ============================================================
        // run parameters
        // ============================================================

        // short frame wait and a shrink period that a tracked game can reach
        localparam int frame_idle    = 20;
        localparam int shrink_period = 400000;
        localparam int pixel_timeout = 200;
        localparam int frame_limit   = 200000;

        logic       CLOCK_50;
        logic [3:0] KEY;
        coord_x_t   x;
        coord_y_t   y;
        colour_t    colour;
        logic       plot;

        // the last plotted pixel and the plot-low cycles in front of it
        int px;
        int py;
        int pc;
        int gap;

        // white span of the previous frame and of the current frame
        int prev_left;
        int prev_width;
        int last_left;
        int last_width;

        // expected puck position and direction and the last purple pixel seen
        int mx;
        int my;
        bit dir_r;
        bit dir_d;
        int purple_x;
        int purple_y;

        // clock cycles seen so far and the end of the last frame with a wider paddle
        int cycle_no;
        int wide_until;

        int misses;
        int bounces;
        int frame_no;
        int seed;
        bit go_right;
        bit go_left;
        bit missed;

        `include "screen_checks.svh"

        pong_screen #(
                .idle_cycles(frame_idle),
                .shrink_cycles(shrink_period)
        ) uut (
                .CLOCK_50(CLOCK_50), .KEY(KEY), .x(x), .y(y), .colour(colour), .plot(plot)
        );

        initial begin
                CLOCK_50 = 1'b0;
                forever #4 CLOCK_50 = ~CLOCK_50;
        end

        task automatic fail_run(input string why);
                $display("%s", why);
                $display("CHECKS FAILED");
                $fatal(1);
        endtask

        // outputs are sampled on the falling edge half a cycle after they settle
        task automatic read_pixel;
                int lows;
                lows = 0;
                @(negedge CLOCK_50);
                cycle_no++;
                while (plot !== 1'b1) begin
                        lows++;
                        if (lows > pixel_timeout)
                                fail_run("plot stayed low longer than any frame wait");
                        @(negedge CLOCK_50);
                        cycle_no++;
                end
                px  = int'(x);
                py  = int'(y);
                pc  = int'(colour);
                gap = lows;
        endtask

        // a restart puts the paddle and the puck back at their start points
        task automatic new_game;
                prev_left  = paddle_x_start;
                prev_width = paddle_len_start + 1;
                last_left  = prev_left;
                last_width = prev_width;
                mx         = faceoff_x;
                my         = faceoff_y;
                dir_r      = 1'b1;
                dir_d      = 1'b1;
                purple_x   = faceoff_x;
                purple_y   = faceoff_y;
        endtask

        // one diagonal step followed by the bounce and miss rules on the new spot
        task automatic advance_puck(output bit lost);
                lost = 1'b0;
                mx   = dir_r ? mx + 1 : mx - 1;
                my   = dir_d ? my + 1 : my - 1;
                if (my == top_line + 1)
                        dir_d = ~dir_d;
                if (mx == left_line + 1 || mx == right_line - 1)
                        dir_r = ~dir_r;
                if (my == paddle_row - 1) begin
                        // the span drawn in this frame decides the outcome
                        if (mx >= last_left && mx <= last_left + last_width - 1) begin
                                dir_d = ~dir_d;
                                bounces++;
                        end else begin
                                lost = 1'b1;
                        end
                end
        endtask

        // ============================================================
        // one frame from the end of the wait to the puck
        // ============================================================

        task automatic play_frame(output bit lost);
                int k;
                read_pixel;
                k = 0;
                while (pc == colour_bg && py == paddle_row) begin
                        paddle_pixel(prev_left, k, colour_bg, (k == 0) ? frame_idle + 1 : 0);
                        k++;
                        read_pixel;
                end
                erase_covers(k);
                // the paddle step leaves one quiet cycle before the redraw
                last_left = px;
                k = 0;
                while (pc == colour_paddle) begin
                        paddle_pixel(last_left, k, colour_paddle, (k == 0) ? 1 : 0);
                        k++;
                        read_pixel;
                end
                last_width = k;
                paddle_span_rules;
                prev_left  = last_left;
                prev_width = last_width;
                pixel_is(purple_x, purple_y, colour_bg, 0);
                advance_puck(lost);
                read_pixel;
                if (lost) begin
                        restart_rules;
                        misses++;
                end else begin
                        puck_draw_rules;
                        purple_x = px;
                        purple_y = py;
                end
        endtask

        // random keys until two misses were seen and after that the paddle follows the puck
        task automatic choose_keys;
                int r;
                int centre;
                if (misses < 2) begin
                        if (frame_no % 4 == 0) begin
                                r        = $random(seed);
                                go_right = r[0];
                                go_left  = r[1];
                        end
                end else begin
                        centre   = last_left + last_width / 2;
                        go_right = (mx > centre);
                        go_left  = (mx < centre);
                end
                @(posedge CLOCK_50);
                KEY[0] <= ~go_right;
                KEY[1] <= ~go_left;
        endtask

        initial begin
                seed       = 97;
                misses     = 0;
                bounces    = 0;
                frame_no   = 0;
                cycle_no   = 0;
                wide_until = 0;
                go_right   = 1'b0;
                go_left    = 1'b0;
                KEY        = 4'b0111;
                repeat (3) @(posedge CLOCK_50);
                KEY[3] <= 1'b1;
                new_game;
                read_pixel;
                // the clear starts right out of reset with no quiet cycle
                expect_eq("plot low cycles", gap, 0);
                clear_pass;
                border_pass;
                // the run ends once the paddle has stayed at its minimum width
                // for two shrink periods inside a single game
                while (misses < 2 || cycle_no - wide_until <= 2 * shrink_period) begin
                        frame_no++;
                        if (frame_no > frame_limit)
                                fail_run("frame limit hit before the paddle shrank to its minimum");
                        play_frame(missed);
                        if (missed) begin
                                clear_pass;
                                border_pass;
                                new_game;
                        end
                        if (last_width > int'(paddle_len_min) + 1)
                                wide_until = cycle_no;
                        choose_keys;
                end
                if (bounces == 0) begin
                        fail_run("the puck never bounced off the paddle");
                end else begin
                        $display("ALL CHECKS PASSED");
                        $finish;
                end
        end

endmodule

`default_nettype wire
